// File: rtl/key_pkg.sv
// shared sizes and encodings for the key input block; num_keys must stay 4 for the status layout
package key_pkg;

    // key panel size
    localparam int num_keys = 4;
    localparam int key_id_w = 2;

    // register port and debounce period
    localparam int cfg_data_w = 16;
    localparam int ticks_w = 16;
    localparam logic [ticks_w-1:0] default_ticks = 16'd16;
    localparam logic [num_keys-1:0] default_enable = '1;

    // overflow flag sits just above the key levels in REG_STATUS
    localparam int status_ovf_bit = num_keys;

    // event word is {key number, pressed}
    localparam int evt_w = key_id_w + 1;
    localparam int evt_fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(evt_fifo_depth);
    localparam int fifo_cnt_w = $clog2(evt_fifo_depth + 1);

    typedef enum logic {
        DB_IDLE  = 1'b0,
        DB_COUNT = 1'b1
    } db_state_e;

    typedef enum logic [1:0] {
        REG_TICKS  = 2'd0,
        REG_ENABLE = 2'd1,
        REG_STATUS = 2'd2
    } cfg_addr_e;

endpackage

// File: rtl/key_debounce.sv
// one active-low key; a level must hold debounce_ticks+1 synchronized cycles to be accepted
`timescale 1ns/10ps

module key_debounce (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      key_raw,
    input  logic [key_pkg::ticks_w-1:0] debounce_ticks,
    output logic                      key_stable,
    output logic                      key_changed
);
    import key_pkg::*;

    logic [1:0]         sync_q;
    logic               key_sync;
    db_state_e          state_q;
    db_state_e          state_d;
    logic [ticks_w-1:0] count_q;
    logic               sample_q;
    logic               level_diff;
    logic               sample_mismatch;
    logic               at_max;

    // two-flop synchronizer, idles at released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], key_raw};
        end
    end

    assign key_sync = sync_q[1];

    assign level_diff      = (key_sync != key_stable);
    assign sample_mismatch = (key_sync != sample_q);
    // >= so a period lowered mid-count still terminates
    assign at_max          = (count_q >= debounce_ticks - ticks_w'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            DB_IDLE: begin
                if (level_diff) begin
                    state_d = DB_COUNT;
                end
            end
            DB_COUNT: begin
                if (sample_mismatch || at_max) begin
                    state_d = DB_IDLE;
                end
            end
            default: state_d = DB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= DB_IDLE;
            count_q     <= '0;
            sample_q    <= 1'b1;
            key_stable  <= 1'b1;
            key_changed <= 1'b0;
        end else begin
            state_q     <= state_d;
            key_changed <= 1'b0;
            if (state_q == DB_IDLE) begin
                count_q  <= '0;
                sample_q <= key_sync;
            end else begin
                count_q <= count_q + ticks_w'(1);
                // a bounce during counting wins over the period end
                if (at_max && !sample_mismatch) begin
                    key_stable  <= sample_q;
                    key_changed <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/key_cfg_regs.sv
// single-cycle register port without handshake; unmapped addresses read 0 and ignore writes
`timescale 1ns/10ps

module key_cfg_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_write,
    input  key_pkg::cfg_addr_e           cfg_addr,
    input  logic [key_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [key_pkg::cfg_data_w-1:0] cfg_rdata,
    input  logic [key_pkg::num_keys-1:0] key_stable,
    input  logic                         overflow_set,
    output logic [key_pkg::ticks_w-1:0]  debounce_ticks,
    output logic [key_pkg::num_keys-1:0] event_enable
);
    import key_pkg::*;

    logic               overflow_q;
    logic [ticks_w-1:0] ticks_wr;
    logic               overflow_clr;

    // zero period would never settle, so it becomes 1
    assign ticks_wr = (cfg_wdata[ticks_w-1:0] == '0) ? ticks_w'(1) : cfg_wdata[ticks_w-1:0];

    assign overflow_clr = cfg_write && (cfg_addr == REG_STATUS) && cfg_wdata[status_ovf_bit];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debounce_ticks <= default_ticks;
            event_enable   <= default_enable;
            overflow_q     <= 1'b0;
        end else begin
            if (cfg_write && (cfg_addr == REG_TICKS)) begin
                debounce_ticks <= ticks_wr;
            end
            if (cfg_write && (cfg_addr == REG_ENABLE)) begin
                event_enable <= cfg_wdata[num_keys-1:0];
            end
            // a new overflow in the clearing cycle is kept
            if (overflow_set) begin
                overflow_q <= 1'b1;
            end else if (overflow_clr) begin
                overflow_q <= 1'b0;
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            REG_TICKS:  cfg_rdata[ticks_w-1:0] = debounce_ticks;
            REG_ENABLE: cfg_rdata[num_keys-1:0] = event_enable;
            REG_STATUS: begin
                cfg_rdata[num_keys-1:0]    = key_stable;
                cfg_rdata[status_ovf_bit] = overflow_q;
            end
            default: cfg_rdata = '0;
        endcase
    end

endmodule

// File: rtl/key_event_collect.sv
// fixed low-index-first priority; an event reports the level at push time, not at the change
`timescale 1ns/10ps

module key_event_collect (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [key_pkg::num_keys-1:0] key_stable,
    input  logic [key_pkg::num_keys-1:0] key_changed,
    input  logic [key_pkg::num_keys-1:0] event_enable,
    input  logic                         full,
    output logic                         push,
    output logic [key_pkg::evt_w-1:0]    push_data,
    output logic                         overflow_set
);
    import key_pkg::*;

    logic [num_keys-1:0] pending_q;
    logic [num_keys-1:0] set_mask;
    logic [num_keys-1:0] clear_mask;
    logic [key_id_w-1:0] sel_id;
    logic                sel_valid;

    assign set_mask = key_changed & event_enable;

    // lowest pending key wins
    always_comb begin
        sel_id    = '0;
        sel_valid = 1'b0;
        for (int i = num_keys - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                sel_id    = key_id_w'(i);
                sel_valid = 1'b1;
            end
        end
    end

    // stall while the fifo has no room
    assign push = sel_valid && !full;

    always_comb begin
        clear_mask = '0;
        if (push) begin
            clear_mask[sel_id] = 1'b1;
        end
    end

    // pressed is the inverse of the active-low level
    assign push_data = {sel_id, ~key_stable[sel_id]};

    // second change before the first was queued
    assign overflow_set = |(set_mask & pending_q & ~clear_mask);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | set_mask;
        end
    end

endmodule

// File: rtl/key_event_fifo.sv
// full includes the word on the output register; pushes while full are dropped
`timescale 1ns/10ps

module key_event_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  logic [key_pkg::evt_w-1:0]    push_data,
    output logic                         full,
    output logic                         evt_valid,
    input  logic                         evt_ready,
    output logic [key_pkg::key_id_w-1:0] evt_key,
    output logic                         evt_pressed
);
    import key_pkg::*;

    logic [evt_w-1:0]      mem [evt_fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr_q;
    logic [fifo_ptr_w-1:0] rd_ptr_q;
    logic [fifo_cnt_w-1:0] count_q;
    logic [fifo_cnt_w-1:0] mem_count;
    logic [evt_w-1:0]      out_word_q;
    logic                  push_ok;
    logic                  pop;
    logic                  load_out;
    logic                  mem_empty;
    logic                  bypass;

    // count covers the buffer and the output stage
    assign full      = (count_q == fifo_cnt_w'(evt_fifo_depth));
    assign push_ok   = push && !full;
    assign pop       = evt_valid && evt_ready;
    assign mem_count = count_q - fifo_cnt_w'(evt_valid);
    assign mem_empty = (mem_count == '0);
    assign load_out  = !evt_valid || pop;
    // empty buffer feeds the output stage straight from the push
    assign bypass    = load_out && mem_empty && push_ok;

    always_ff @(posedge clk) begin
        if (push_ok && !bypass) begin
            mem[wr_ptr_q] <= push_data;
        end
        if (load_out) begin
            if (!mem_empty) begin
                out_word_q <= mem[rd_ptr_q];
            end else if (push_ok) begin
                out_word_q <= push_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            evt_valid <= 1'b0;
        end else begin
            if (push_ok && !bypass) begin
                wr_ptr_q <= wr_ptr_q + fifo_ptr_w'(1);
            end
            if (load_out) begin
                if (!mem_empty) begin
                    rd_ptr_q  <= rd_ptr_q + fifo_ptr_w'(1);
                    evt_valid <= 1'b1;
                end else begin
                    evt_valid <= push_ok;
                end
            end
            count_q <= count_q + fifo_cnt_w'(push_ok) - fifo_cnt_w'(pop);
        end
    end

    assign evt_key     = out_word_q[evt_w-1:1];
    assign evt_pressed = out_word_q[0];

endmodule

// File: rtl/key_input_top.sv
// debounced key panel; keys are active low, period in clock ticks set through REG_TICKS
`timescale 1ns/10ps

module key_input_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [key_pkg::num_keys-1:0]   key_raw,
    input  logic                           cfg_write,
    input  key_pkg::cfg_addr_e             cfg_addr,
    input  logic [key_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [key_pkg::cfg_data_w-1:0] cfg_rdata,
    output logic                           evt_valid,
    input  logic                           evt_ready,
    output logic [key_pkg::key_id_w-1:0]   evt_key,
    output logic                           evt_pressed
);
    import key_pkg::*;

    logic [ticks_w-1:0]  debounce_ticks;
    logic [num_keys-1:0] event_enable;
    logic [num_keys-1:0] key_stable;
    logic [num_keys-1:0] key_changed;
    logic                push;
    logic [evt_w-1:0]    push_data;
    logic                full;
    logic                overflow_set;

    for (genvar i = 0; i < num_keys; i++) begin : g_key
        key_debounce i_debounce (
            .clk            (clk),
            .rst_n          (rst_n),
            .key_raw        (key_raw[i]),
            .debounce_ticks (debounce_ticks),
            .key_stable     (key_stable[i]),
            .key_changed    (key_changed[i])
        );
    end

    key_cfg_regs i_cfg_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_write      (cfg_write),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .key_stable     (key_stable),
        .overflow_set   (overflow_set),
        .debounce_ticks (debounce_ticks),
        .event_enable   (event_enable)
    );

    key_event_collect i_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_stable   (key_stable),
        .key_changed  (key_changed),
        .event_enable (event_enable),
        .full         (full),
        .push         (push),
        .push_data    (push_data),
        .overflow_set (overflow_set)
    );

    key_event_fifo i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_data   (push_data),
        .full        (full),
        .evt_valid   (evt_valid),
        .evt_ready   (evt_ready),
        .evt_key     (evt_key),
        .evt_pressed (evt_pressed)
    );

endmodule

// File: testbench/key_input_props.sv
// event port checks, bound into every key_input_top; payload is only meaningful while valid
`timescale 1ns/10ps

module key_input_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         evt_valid,
    input logic                         evt_ready,
    input logic [key_pkg::key_id_w-1:0] evt_key,
    input logic                         evt_pressed
);

    // asynchronous reset clears the output stage
    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !evt_valid)
        else $error("evt_valid high while reset is asserted");

    // stalled word holds still
    payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (evt_valid && !evt_ready) |=> $stable({evt_key, evt_pressed}))
        else $error("event payload changed while stalled");

    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (evt_valid && !evt_ready) |=> evt_valid)
        else $error("evt_valid dropped without a transfer");

endmodule

bind key_input_top key_input_props i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .evt_valid   (evt_valid),
    .evt_ready   (evt_ready),
    .evt_key     (evt_key),
    .evt_pressed (evt_pressed)
);

// File: testbench/key_input_tb.sv
// table holds assume the 16-tick reset period except where a phase rewrites REG_TICKS
`timescale 1ns/10ps

module key_input_tb;
    import key_pkg::*;

    typedef struct packed {
        logic [key_id_w-1:0] key;
        logic                level;
        logic [7:0]          hold;
        logic                evt;
    } step_t;

    localparam int num_steps = 34;

    // key, raw level, hold cycles, event expected
    step_t steps [num_steps] = '{
        // clean press and release
        '{2'd0, 1'b0, 8'd30, 1'b1}, '{2'd0, 1'b1, 8'd30, 1'b1},
        '{2'd2, 1'b0, 8'd30, 1'b1}, '{2'd2, 1'b1, 8'd30, 1'b1},
        // glitches below the period
        '{2'd1, 1'b0, 8'd5, 1'b0}, '{2'd1, 1'b1, 8'd20, 1'b0},
        '{2'd1, 1'b0, 8'd10, 1'b0}, '{2'd1, 1'b1, 8'd20, 1'b0},
        '{2'd3, 1'b0, 8'd15, 1'b0}, '{2'd3, 1'b1, 8'd25, 1'b0},
        // 25 cycle glitch, period 16 then period 40
        '{2'd1, 1'b0, 8'd25, 1'b1}, '{2'd1, 1'b1, 8'd25, 1'b1},
        '{2'd1, 1'b0, 8'd25, 1'b0}, '{2'd1, 1'b1, 8'd50, 1'b0},
        // key 3 masked off
        '{2'd3, 1'b0, 8'd50, 1'b0}, '{2'd3, 1'b1, 8'd50, 1'b0},
        // all keys at once, zero hold means same time step
        '{2'd0, 1'b0, 8'd0, 1'b1}, '{2'd1, 1'b0, 8'd0, 1'b1},
        '{2'd2, 1'b0, 8'd0, 1'b1}, '{2'd3, 1'b0, 8'd30, 1'b1},
        '{2'd0, 1'b1, 8'd0, 1'b1}, '{2'd1, 1'b1, 8'd0, 1'b1},
        '{2'd2, 1'b1, 8'd0, 1'b1}, '{2'd3, 1'b1, 8'd30, 1'b1},
        // 8 fill the FIFO, the 9th waits pending, the 10th merges into it
        '{2'd0, 1'b0, 8'd25, 1'b1}, '{2'd0, 1'b1, 8'd25, 1'b1},
        '{2'd0, 1'b0, 8'd25, 1'b1}, '{2'd0, 1'b1, 8'd25, 1'b1},
        '{2'd0, 1'b0, 8'd25, 1'b1}, '{2'd0, 1'b1, 8'd25, 1'b1},
        '{2'd0, 1'b0, 8'd25, 1'b1}, '{2'd0, 1'b1, 8'd25, 1'b1},
        '{2'd0, 1'b0, 8'd25, 1'b0}, '{2'd0, 1'b1, 8'd25, 1'b1}
    };

    logic                  clk;
    logic                  rst_n;
    logic [num_keys-1:0]   key_raw;
    logic                  cfg_write;
    cfg_addr_e             cfg_addr;
    logic [cfg_data_w-1:0] cfg_wdata;
    logic [cfg_data_w-1:0] cfg_rdata;
    logic                  evt_valid;
    logic                  evt_ready;
    logic [key_id_w-1:0]   evt_key;
    logic                  evt_pressed;

    logic [evt_w-1:0] expected_q [$];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit;
    // 0 ready high, 1 ready held low, 2 random stalls
    int ready_mode = 0;
    int stall_left = 0;
    // status levels held during the glitch phase
    logic                status_watch = 1'b0;
    logic [num_keys-1:0] stable_exp;

    key_input_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_raw     (key_raw),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .evt_valid   (evt_valid),
        .evt_ready   (evt_ready),
        .evt_key     (evt_key),
        .evt_pressed (evt_pressed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_steps(input int first, input int last);
        for (int s = first; s <= last; s++) begin
            key_raw[steps[s].key] = steps[s].level;
            // pressed is the inverse of the active-low level
            if (steps[s].evt) begin
                expected_q.push_back({steps[s].key, ~steps[s].level});
            end
            wait_cycles(steps[s].hold);
        end
    endtask

    task automatic reg_write(input cfg_addr_e addr, input logic [15:0] data);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_write = 1'b1;
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic reg_check(input cfg_addr_e addr, input logic [15:0] exp);
        cfg_addr = addr;
        @(negedge clk);
        checks++;
        assert (cfg_rdata === exp) else begin
            errors++;
            $display("** Error: cfg_rdata at %s expected %h got %h", addr.name(), exp, cfg_rdata);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain;
        if (expected_q.size() != 0) begin
            while (expected_q.size() != 0) begin
                @(posedge clk);
            end
            #1;
        end
    endtask

    // settled levels equal the raw lines once every hold has run out
    function automatic logic [15:0] status_value(input logic ovf);
        logic [15:0] v;
        v = '0;
        v[3:0] = key_raw;
        v[4] = ovf;
        return v;
    endfunction

    always @(posedge clk) begin : ready_drive
        int mode_now;
        mode_now = ready_mode;
        #1;
        case (mode_now)
            0: evt_ready = 1'b1;
            1: evt_ready = 1'b0;
            default: begin
                if (stall_left > 0) begin
                    evt_ready = 1'b0;
                    stall_left--;
                end else begin
                    evt_ready = 1'b1;
                    stall_left = $urandom % 5;
                end
            end
        endcase
    end

    // glitches must never reach the stable levels
    always @(negedge clk) begin : status_hold_check
        if (status_watch) begin
            checks++;
            assert (cfg_rdata[num_keys-1:0] === stable_exp) else begin
                errors++;
                $display("** Error: cfg_rdata stable bits expected %h got %h",
                         stable_exp, cfg_rdata[num_keys-1:0]);
            end
        end
    end

    // scoreboard, transfer happens at the following rising edge
    always @(negedge clk) begin : monitor
        logic [evt_w-1:0] exp_word;
        if (rst_n && evt_valid && evt_ready) begin
            checks++;
            assert (expected_q.size() != 0) else begin
                errors++;
                $display("event from key %0d arrived while none was expected", evt_key);
            end
            if (expected_q.size() != 0) begin
                exp_word = expected_q.pop_front();
                checks += 2;
                assert (evt_key === exp_word[evt_w-1:1]) else begin
                    errors++;
                    $display("** Error: evt_key expected %h got %h", exp_word[evt_w-1:1], evt_key);
                end
                assert (evt_pressed === exp_word[0]) else begin
                    errors++;
                    $display("** Error: evt_pressed expected %h got %h", exp_word[0], evt_pressed);
                end
            end
        end
    end

    initial begin : watchdog
        cycle_limit = 2000;
        for (int s = 0; s < num_steps; s++) begin
            cycle_limit += steps[s].hold;
        end
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles, %0d events never arrived",
                         cycle_limit, expected_q.size());
                $display("checks: %0d, errors: %0d", checks, errors);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(32'h74c3f959));
        rst_n     = 1'b0;
        key_raw   = '1;
        cfg_write = 1'b0;
        cfg_addr  = REG_TICKS;
        cfg_wdata = '0;
        evt_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values
        reg_check(REG_TICKS, 16'd16);
        reg_check(REG_ENABLE, 16'h000f);
        reg_check(REG_STATUS, 16'h000f);

        apply_steps(0, 3);
        // watch the status levels through every glitch
        cfg_addr     = REG_STATUS;
        stable_exp   = key_raw;
        status_watch = 1'b1;
        apply_steps(4, 9);
        status_watch = 1'b0;
        reg_check(REG_STATUS, status_value(1'b0));

        apply_steps(10, 11);
        // zero period is stored as 1
        reg_write(REG_TICKS, 16'd0);
        reg_check(REG_TICKS, 16'd1);
        reg_write(REG_TICKS, 16'd40);
        reg_check(REG_TICKS, 16'd40);
        reg_write(REG_ENABLE, 16'h0007);
        reg_check(REG_ENABLE, 16'h0007);
        apply_steps(12, 14);
        reg_check(REG_STATUS, status_value(1'b0));
        apply_steps(15, 15);
        reg_write(REG_TICKS, 16'd16);
        reg_write(REG_ENABLE, 16'h000f);
        wait_drain();

        // group changes behind a stalled consumer
        ready_mode = 1;
        apply_steps(16, 23);
        ready_mode = 2;
        wait_drain();

        ready_mode = 1;
        apply_steps(24, 33);
        reg_check(REG_STATUS, status_value(1'b1));
        reg_write(REG_STATUS, 16'h0010);
        reg_check(REG_STATUS, status_value(1'b0));
        ready_mode = 2;
        wait_drain();

        // let any stray event surface at the monitor
        ready_mode = 0;
        wait_cycles(20);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/key_pkg.sv
rtl/key_debounce.sv
rtl/key_cfg_regs.sv
rtl/key_event_collect.sv
rtl/key_event_fifo.sv
rtl/key_input_top.sv
testbench/key_input_props.sv
testbench/key_input_tb.sv

// File: Bender.yml
package:
  name: key_input

sources:
  - rtl/key_pkg.sv
  - rtl/key_debounce.sv
  - rtl/key_cfg_regs.sv
  - rtl/key_event_collect.sv
  - rtl/key_event_fifo.sv
  - rtl/key_input_top.sv
  - target: test
    files:
      - testbench/key_input_props.sv
      - testbench/key_input_tb.sv
